// File: design/lsq_settings.svh
// load/store unit settings
`ifndef LSQ_SETTINGS_SVH
`define LSQ_SETTINGS_SVH

// data and address width
`define LSQ_XLEN 32

// entries in every queue fifo
`define LSQ_FIFO_DEPTH 4

// data ram size in words
// word indices at or above this fault
`define LSQ_RAM_WORDS 64

`endif

// File: design/lsq_pkg.sv
// load/store operation types
`include "lsq_settings.svh"

package lsq_pkg;

    typedef logic [`LSQ_XLEN-1:0] lsq_word_t;

    // loads keep their rv32 funct3 codes
    // stores take the three codes rv32 loads leave free
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        SB  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        SH  = 3'b110,
        SW  = 3'b111
    } mem_op_t;

    // one accepted execute-stage operation
    // data holds the store data, or rd for a load
    typedef struct packed {
        lsq_word_t addr;
        lsq_word_t data;
        mem_op_t   op;
        logic      store;
    } req_entry_t;

    // what writeback needs to format a load response
    typedef struct packed {
        logic [1:0] offset;
        logic [4:0] rd;
        mem_op_t    op;
    } rsp_ctrl_t;

endpackage

// File: design/dport_pkg.sv
// data port types

package dport_pkg;

    // access size on the request channel
    typedef enum logic [1:0] {
        DSIZE_BYTE = 2'b00,
        DSIZE_HALF = 2'b01,
        DSIZE_WORD = 2'b10
    } dsize_t;

endpackage

// File: design/lsq_fifo.sv
// generic synchronous fifo
`include "lsq_settings.svh"

module lsq_fifo #(
    parameter type payload_t = logic [`LSQ_XLEN-1:0]
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     wr_i,
    input  payload_t din_i,
    output logic     full_o,
    input  logic     rd_i,
    output payload_t dout_o,
    output logic     empty_o
);

    localparam int DEPTH = `LSQ_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    // wrap at depth even when it is not a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign push    = wr_i & ~full_o;
    assign pop     = rd_i & ~empty_o;
    assign dout_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= din_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            // count only moves when exactly one side is active
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: design/lsq_load_formatter.sv
// load response formatter

module lsq_load_formatter (
    input  logic [1:0]         offset_i,
    input  lsq_pkg::mem_op_t   op_i,
    input  lsq_pkg::lsq_word_t word_i,
    output lsq_pkg::lsq_word_t data_o
);

    import lsq_pkg::*;

    lsq_word_t justified;

    // bring the addressed lane down to bit 0
    assign justified = word_i >> {offset_i, 3'b000};

    // signed sources widen with their sign bit
    always_comb begin
        case (op_i)
            LB: begin
                data_o = lsq_word_t'(signed'(justified[7:0]));
            end
            LH: begin
                data_o = lsq_word_t'(signed'(justified[15:0]));
            end
            LBU: begin
                data_o = lsq_word_t'(justified[7:0]);
            end
            LHU: begin
                data_o = lsq_word_t'(justified[15:0]);
            end
            default: begin
                // offset is always zero for LW
                data_o = justified;
            end
        endcase
    end

endmodule

// File: design/lsq_queue.sv
// load/store queue

module lsq_queue (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // execute stage
    input  logic                 exs_valid_i,
    output logic                 exs_ready_o,
    input  logic                 exs_store_i,
    input  lsq_pkg::mem_op_t     exs_op_i,
    input  logic [4:0]           exs_rd_i,
    input  lsq_pkg::lsq_word_t   exs_addr_i,
    input  lsq_pkg::lsq_word_t   exs_store_data_i,
    output logic                 idle_o,
    // writeback and faults
    output logic                 wb_valid_o,
    output logic [4:0]           wb_rd_o,
    output lsq_pkg::lsq_word_t   wb_data_o,
    output logic                 laf_o,
    output logic                 saf_o,
    // data port
    output logic                 dreq_valid_o,
    input  logic                 dreq_ready_i,
    output logic                 dreq_write_o,
    output dport_pkg::dsize_t    dreq_size_o,
    output lsq_pkg::lsq_word_t   dreq_addr_o,
    output lsq_pkg::lsq_word_t   dreq_data_o,
    input  logic                 drsp_valid_i,
    output logic                 drsp_ready_o,
    input  logic                 drsp_rerr_i,
    input  logic                 drsp_werr_i,
    input  lsq_pkg::lsq_word_t   drsp_data_i
);

    import lsq_pkg::*;
    import dport_pkg::*;

    logic       req_wr;
    req_entry_t req_din;
    req_entry_t req_dout;
    logic       req_full;
    logic       req_empty;
    logic       request;

    rsp_ctrl_t  ctrl_din;
    rsp_ctrl_t  ctrl_dout;
    logic       ctrl_full;
    logic       ctrl_empty;

    lsq_word_t  data_din;
    lsq_word_t  data_dout;
    logic       data_full;
    logic       data_empty;
    logic       rsp_accept;

    // the ram answers one access at a time
    logic       pend_valid_q;
    logic       pend_store_q;

    // ------------------------------
    // request fifo
    // ------------------------------
    assign exs_ready_o = ~req_full;
    assign req_wr      = exs_valid_i & exs_ready_o;

    always_comb begin
        req_din.addr  = exs_addr_i;
        req_din.data  = exs_store_i ? exs_store_data_i : lsq_word_t'(exs_rd_i);
        req_din.op    = exs_op_i;
        req_din.store = exs_store_i;
    end

    lsq_fifo #(.payload_t(req_entry_t)) u_req_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wr_i    (req_wr),
        .din_i   (req_din),
        .full_o  (req_full),
        .rd_i    (request),
        .dout_o  (req_dout),
        .empty_o (req_empty)
    );

    // ------------------------------
    // data port control
    // ------------------------------
    assign dreq_valid_o = ~req_empty & ~ctrl_full;
    assign request      = dreq_valid_o & dreq_ready_i;
    assign dreq_write_o = req_dout.store;
    assign dreq_addr_o  = req_dout.addr;
    assign dreq_data_o  = req_dout.data;

    always_comb begin
        case (req_dout.op)
            LB, LBU, SB: dreq_size_o = DSIZE_BYTE;
            LH, LHU, SH: dreq_size_o = DSIZE_HALF;
            default:     dreq_size_o = DSIZE_WORD;
        endcase
    end

    // store responses never need room in the data fifo
    assign drsp_ready_o = pend_store_q | ~data_full;
    assign rsp_accept   = drsp_valid_i & drsp_ready_o;
    assign laf_o        = rsp_accept & drsp_rerr_i;
    assign saf_o        = rsp_accept & drsp_werr_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_valid_q <= 1'b0;
            pend_store_q <= 1'b0;
        end else if (request) begin
            pend_valid_q <= 1'b1;
            pend_store_q <= dreq_write_o;
        end else if (rsp_accept) begin
            pend_valid_q <= 1'b0;
            pend_store_q <= 1'b0;
        end
    end

    assign idle_o = req_empty & ctrl_empty & data_empty & ~pend_valid_q;

    // ------------------------------
    // response fifos
    // ------------------------------
    always_comb begin
        ctrl_din.offset = req_dout.addr[1:0];
        ctrl_din.rd     = req_dout.data[4:0];
        ctrl_din.op     = req_dout.op;
    end

    lsq_fifo #(.payload_t(rsp_ctrl_t)) u_ctrl_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wr_i    (request & ~req_dout.store),
        .din_i   (ctrl_din),
        .full_o  (ctrl_full),
        .rd_i    (wb_valid_o),
        .dout_o  (ctrl_dout),
        .empty_o (ctrl_empty)
    );

    // faulting load returns zero
    assign data_din = drsp_rerr_i ? '0 : drsp_data_i;

    lsq_fifo #(.payload_t(lsq_word_t)) u_data_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wr_i    (rsp_accept & ~pend_store_q),
        .din_i   (data_din),
        .full_o  (data_full),
        .rd_i    (wb_valid_o),
        .dout_o  (data_dout),
        .empty_o (data_empty)
    );

    // ------------------------------
    // writeback
    // ------------------------------
    assign wb_valid_o = ~data_empty;
    assign wb_rd_o    = ctrl_dout.rd;

    lsq_load_formatter u_formatter (
        .offset_i (ctrl_dout.offset),
        .op_i     (ctrl_dout.op),
        .word_i   (data_dout),
        .data_o   (wb_data_o)
    );

endmodule

// File: design/lsq_data_ram.sv
// local data memory
`include "lsq_settings.svh"

module lsq_data_ram (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               dreq_valid_i,
    output logic               dreq_ready_o,
    input  logic               dreq_write_i,
    input  dport_pkg::dsize_t  dreq_size_i,
    input  lsq_pkg::lsq_word_t dreq_addr_i,
    input  lsq_pkg::lsq_word_t dreq_data_i,
    output logic               drsp_valid_o,
    input  logic               drsp_ready_i,
    output logic               drsp_rerr_o,
    output logic               drsp_werr_o,
    output lsq_pkg::lsq_word_t drsp_data_o
);

    import lsq_pkg::*;
    import dport_pkg::*;

    localparam int IDX_W = $clog2(`LSQ_RAM_WORDS);

    lsq_word_t        mem_q [`LSQ_RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             in_range;
    logic             access;
    logic [3:0]       lane_en;
    lsq_word_t        lane_data;

    assign idx      = dreq_addr_i[IDX_W+1:2];
    assign in_range = (dreq_addr_i[`LSQ_XLEN-1:2] < `LSQ_RAM_WORDS);
    // next request may enter while the held response leaves
    assign dreq_ready_o = ~drsp_valid_o | drsp_ready_i;
    assign access       = dreq_valid_i & dreq_ready_o;

    // byte lanes touched by a store
    always_comb begin
        case (dreq_size_i)
            DSIZE_BYTE: lane_en = 4'b0001 << dreq_addr_i[1:0];
            DSIZE_HALF: lane_en = 4'b0011 << {dreq_addr_i[1], 1'b0};
            default:    lane_en = 4'b1111;
        endcase
    end

    assign lane_data = dreq_data_i << {dreq_addr_i[1:0], 3'b000};

    always_ff @(posedge clk_i) begin
        if (access && dreq_write_i && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_en[b]) begin
                    mem_q[idx][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
    end

    // registered read word
    always_ff @(posedge clk_i) begin
        if (access) begin
            drsp_data_o <= mem_q[idx];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            drsp_valid_o <= 1'b0;
            drsp_rerr_o  <= 1'b0;
            drsp_werr_o  <= 1'b0;
        end else if (access) begin
            drsp_valid_o <= 1'b1;
            drsp_rerr_o  <= ~dreq_write_i & ~in_range;
            drsp_werr_o  <= dreq_write_i & ~in_range;
        end else if (drsp_ready_i) begin
            drsp_valid_o <= 1'b0;
        end
    end

endmodule

// File: design/lsu_top.sv
// load/store unit with data memory

module lsu_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               exs_valid_i,
    output logic               exs_ready_o,
    input  logic               exs_store_i,
    input  lsq_pkg::mem_op_t   exs_op_i,
    input  logic [4:0]         exs_rd_i,
    input  lsq_pkg::lsq_word_t exs_addr_i,
    input  lsq_pkg::lsq_word_t exs_store_data_i,
    output logic               idle_o,
    output logic               wb_valid_o,
    output logic [4:0]         wb_rd_o,
    output lsq_pkg::lsq_word_t wb_data_o,
    output logic               laf_o,
    output logic               saf_o
);

    import lsq_pkg::*;
    import dport_pkg::*;

    // ------------------------------
    // data port
    // ------------------------------
    logic      dreq_valid;
    logic      dreq_ready;
    logic      dreq_write;
    dsize_t    dreq_size;
    lsq_word_t dreq_addr;
    lsq_word_t dreq_data;
    logic      drsp_valid;
    logic      drsp_ready;
    logic      drsp_rerr;
    logic      drsp_werr;
    lsq_word_t drsp_data;

    lsq_queue u_queue (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .exs_valid_i      (exs_valid_i),
        .exs_ready_o      (exs_ready_o),
        .exs_store_i      (exs_store_i),
        .exs_op_i         (exs_op_i),
        .exs_rd_i         (exs_rd_i),
        .exs_addr_i       (exs_addr_i),
        .exs_store_data_i (exs_store_data_i),
        .idle_o           (idle_o),
        .wb_valid_o       (wb_valid_o),
        .wb_rd_o          (wb_rd_o),
        .wb_data_o        (wb_data_o),
        .laf_o            (laf_o),
        .saf_o            (saf_o),
        .dreq_valid_o     (dreq_valid),
        .dreq_ready_i     (dreq_ready),
        .dreq_write_o     (dreq_write),
        .dreq_size_o      (dreq_size),
        .dreq_addr_o      (dreq_addr),
        .dreq_data_o      (dreq_data),
        .drsp_valid_i     (drsp_valid),
        .drsp_ready_o     (drsp_ready),
        .drsp_rerr_i      (drsp_rerr),
        .drsp_werr_i      (drsp_werr),
        .drsp_data_i      (drsp_data)
    );

    lsq_data_ram u_ram (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .dreq_valid_i (dreq_valid),
        .dreq_ready_o (dreq_ready),
        .dreq_write_i (dreq_write),
        .dreq_size_i  (dreq_size),
        .dreq_addr_i  (dreq_addr),
        .dreq_data_i  (dreq_data),
        .drsp_valid_o (drsp_valid),
        .drsp_ready_i (drsp_ready),
        .drsp_rerr_o  (drsp_rerr),
        .drsp_werr_o  (drsp_werr),
        .drsp_data_o  (drsp_data)
    );

endmodule

// File: sim/lsq_checker.sv
// writeback and fault checker

module lsq_checker (
    input logic               clk_i,
    input logic               rst_n_i,
    input logic               wb_valid_i,
    input logic [4:0]         wb_rd_i,
    input lsq_pkg::lsq_word_t wb_data_i,
    input logic               laf_i,
    input logic               saf_i
);

    timeunit 1ns;
    timeprecision 1ps;

    import lsq_pkg::*;

    // outstanding loads in issue order
    logic [4:0] exp_rd_q[$];
    lsq_word_t  exp_data_q[$];
    logic       exp_fault_q[$];

    int error_count = 0;
    int laf_expected = 0;
    int saf_expected = 0;
    int laf_seen = 0;
    int saf_seen = 0;
    // laf pulses not yet matched to a writeback
    int laf_unmatched = 0;

    task automatic value_error(input string msg);
        error_count++;
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
    endtask

    task automatic protocol_error(input string msg);
        error_count++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    task automatic expect_load(input logic [4:0] rd, input lsq_word_t value, input logic fault);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(value);
        exp_fault_q.push_back(fault);
        if (fault) begin
            laf_expected++;
        end
    endtask

    task automatic expect_store(input logic fault);
        if (fault) begin
            saf_expected++;
        end
    endtask

    task automatic check_writeback();
        logic [4:0] rd;
        lsq_word_t  value;
        logic       fault;
        if (exp_rd_q.size() == 0) begin
            protocol_error($sformatf("writeback to x%0d with no load outstanding", wb_rd_i));
        end else begin
            rd    = exp_rd_q.pop_front();
            value = exp_data_q.pop_front();
            fault = exp_fault_q.pop_front();
            if (wb_rd_i !== rd) begin
                value_error($sformatf("writeback rd x%0d, expected x%0d", wb_rd_i, rd));
            end
            if (wb_data_i !== value) begin
                value_error($sformatf("writeback x%0d data %h, expected %h",
                                      rd, wb_data_i, value));
            end
            // the fault pulse of a load comes before its writeback
            if (fault && laf_unmatched == 0) begin
                value_error($sformatf("faulting load to x%0d wrote back without laf_o", rd));
            end else if (fault) begin
                laf_unmatched--;
            end
        end
    endtask

    task automatic close_checks();
        if (exp_rd_q.size() != 0) begin
            protocol_error($sformatf("%0d load writebacks never arrived", exp_rd_q.size()));
        end
        if (laf_seen != laf_expected) begin
            value_error($sformatf("%0d laf_o pulses, expected %0d", laf_seen, laf_expected));
        end
        if (saf_seen != saf_expected) begin
            value_error($sformatf("%0d saf_o pulses, expected %0d", saf_seen, saf_expected));
        end
    endtask

    // sample the DUT outputs mid-cycle
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (laf_i) begin
                laf_seen++;
                laf_unmatched++;
            end
            if (saf_i) begin
                saf_seen++;
            end
            if (wb_valid_i) begin
                check_writeback();
            end
        end
    end

endmodule

// File: sim/lsq_tb.sv
// load/store unit testbench

module lsq_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import lsq_pkg::*;

    localparam int READY_TIMEOUT = 50;
    localparam int IDLE_TIMEOUT  = 200;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       exs_valid;
    logic       exs_ready;
    logic       exs_store;
    mem_op_t    exs_op;
    logic [4:0] exs_rd;
    lsq_word_t  exs_addr;
    lsq_word_t  exs_store_data;
    logic       idle;
    logic       wb_valid;
    logic [4:0] wb_rd;
    lsq_word_t  wb_data;
    logic       laf;
    logic       saf;

    integer seed = 32'h4fb1_48ff;
    int     tb_errors = 0;
    int     timeout_count = 0;
    logic   timed_out = 1'b0;

    always #50 clk = ~clk;

    lsu_top dut_i (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .exs_valid_i      (exs_valid),
        .exs_ready_o      (exs_ready),
        .exs_store_i      (exs_store),
        .exs_op_i         (exs_op),
        .exs_rd_i         (exs_rd),
        .exs_addr_i       (exs_addr),
        .exs_store_data_i (exs_store_data),
        .idle_o           (idle),
        .wb_valid_o       (wb_valid),
        .wb_rd_o          (wb_rd),
        .wb_data_o        (wb_data),
        .laf_o            (laf),
        .saf_o            (saf)
    );

    lsq_checker u_checker (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .wb_valid_i (wb_valid),
        .wb_rd_i    (wb_rd),
        .wb_data_i  (wb_data),
        .laf_i      (laf),
        .saf_i      (saf)
    );

    // ------------------------------
    // execute-side driver
    // ------------------------------

    // called on a rising edge and returns on the handshake edge
    task automatic issue_op(input logic store, input logic [2:0] op, input lsq_word_t addr,
                            input lsq_word_t data, input logic [4:0] rd);
        int waited;
        waited = 0;
        exs_valid      <= 1'b1;
        exs_store      <= store;
        exs_op         <= mem_op_t'(op);
        exs_addr       <= addr;
        exs_store_data <= data;
        exs_rd         <= rd;
        @(negedge clk);
        while (!exs_ready && waited < READY_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!exs_ready) begin
            timed_out = 1'b1;
            timeout_count++;
            $display("timeout at %0d ns: exs_ready_o stayed low", $time);
        end
        @(posedge clk);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!idle && waited < IDLE_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!idle) begin
            timeout_count++;
            $display("timeout at %0d ns: idle_o never returned high", $time);
        end
    endtask

    // ------------------------------
    // vector run
    // ------------------------------
    initial begin
        int        fd;
        int        n;
        int        gap;
        string     line;
        logic [31:0] v_store, v_op, v_addr, v_data, v_rd, v_exp, v_fault;

        rst_n          = 1'b0;
        exs_valid      = 1'b0;
        exs_store      = 1'b0;
        exs_op         = LW;
        exs_rd         = '0;
        exs_addr       = '0;
        exs_store_data = '0;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        fd = $fopen("sim/lsq_vectors.txt", "r");
        if (fd == 0) begin
            tb_errors++;
            $display("could not open sim/lsq_vectors.txt");
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                n = $fgets(line, fd);
                // skip blank and comment lines
                if (line.len() >= 2 && line[0] != 8'h23) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h",
                                v_store, v_op, v_addr, v_data, v_rd, v_exp, v_fault);
                    if (n != 7) begin
                        tb_errors++;
                        $display("malformed vector line: %s", line);
                    end else begin
                        issue_op(v_store[0], v_op[2:0], v_addr, v_data, v_rd[4:0]);
                        if (!timed_out && v_store[0]) begin
                            u_checker.expect_store(v_fault[0]);
                        end else if (!timed_out) begin
                            u_checker.expect_load(v_rd[4:0], v_exp, v_fault[0]);
                        end
                        gap = $unsigned($random(seed)) % 4;
                        if (gap > 0) begin
                            exs_valid <= 1'b0;
                            repeat (gap) @(posedge clk);
                        end
                    end
                end
            end
            $fclose(fd);
        end

        exs_valid <= 1'b0;
        if (!timed_out) begin
            wait_idle();
        end
        @(posedge clk);
        u_checker.close_checks();

        $display("errors %0d, timeouts %0d", u_checker.error_count + tb_errors, timeout_count);
        if (u_checker.error_count + tb_errors == 0 && timeout_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sim/lsq_vectors.txt
# store op addr store_data rd expected fault, all hex
# op codes: 0 LB, 1 LH, 2 LW, 3 SB, 4 LBU, 5 LHU, 6 SH, 7 SW
1 7 00000000 12345678 00 00000000 0
0 2 00000000 00000000 05 12345678 0
1 7 00000010 f08c7a81 00 00000000 0
0 0 00000010 00000000 01 ffffff81 0
0 0 00000011 00000000 02 0000007a 0
0 0 00000012 00000000 03 ffffff8c 0
0 0 00000013 00000000 04 fffffff0 0
0 4 00000010 00000000 06 00000081 0
0 4 00000011 00000000 07 0000007a 0
0 4 00000012 00000000 08 0000008c 0
0 4 00000013 00000000 09 000000f0 0
0 1 00000010 00000000 0a 00007a81 0
0 1 00000012 00000000 0b fffff08c 0
0 5 00000010 00000000 0c 00007a81 0
0 5 00000012 00000000 0d 0000f08c 0
1 7 00000020 00000000 00 00000000 0
1 3 00000021 ffffffab 00 00000000 0
1 6 00000022 1234cdef 00 00000000 0
1 3 00000020 00000011 00 00000000 0
0 2 00000020 00000000 0e cdefab11 0
1 7 00000024 11223344 00 00000000 0
1 6 00000024 00005566 00 00000000 0
0 2 00000024 00000000 0f 11225566 0
0 2 00000100 00000000 10 00000000 1
0 0 000003ff 00000000 11 00000000 1
1 7 00000104 deadbeef 00 00000000 1
0 2 00000000 00000000 12 12345678 0
1 7 00000030 a5a55a5a 00 00000000 0
1 7 000000fc 0badf00d 00 00000000 0
0 2 000000fc 00000000 13 0badf00d 0
0 5 00000032 00000000 14 0000a5a5 0
0 0 00000030 00000000 15 0000005a 0
1 6 00000200 00000001 00 00000000 1
0 1 00000032 00000000 16 ffffa5a5 0
0 2 00000030 00000000 17 a5a55a5a 0
0 2 00000010 00000000 1f f08c7a81 0

// File: sources.f
+incdir+design
design/lsq_pkg.sv
design/dport_pkg.sv
design/lsq_fifo.sv
design/lsq_load_formatter.sv
design/lsq_queue.sv
design/lsq_data_ram.sv
design/lsu_top.sv
sim/lsq_checker.sv
sim/lsq_tb.sv
